/* source/mips_pkg.sv */
`default_nettype none

package mips_pkg;

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [DATA_W-1:0] RESET_VECTOR = 32'hBFC0_0000;
    // Reaching this address ends the program
    localparam logic [DATA_W-1:0] HALT_ADDR    = 32'h0000_0000;

    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [DATA_W/8-1:0]   byte_en_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } state_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0A,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_XORI    = 6'h0E,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_t;

    // Function field of SPECIAL instructions
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLT  = 6'h2A,
        F_SLTU = 6'h2B
    } funct_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_BEQ,
        BR_BNE,
        BR_J,
        BR_JR
    } branch_t;

endpackage

`default_nettype wire

/* source/instr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  mips_pkg::word_t     ir,
    output mips_pkg::reg_addr_t rs,
    output mips_pkg::reg_addr_t rt,
    output mips_pkg::reg_addr_t dest,
    output logic [4:0]          shamt,
    output mips_pkg::alu_op_t   alu_op,
    output logic                use_imm,
    output mips_pkg::word_t     imm_ext,
    output logic                reg_write,
    output logic                is_load,
    output logic                is_store,
    output mips_pkg::branch_t   branch,
    output logic [25:0]         jump_index
);
    import mips_pkg::*;

    opcode_t opcode;
    funct_t  funct;
    logic    zero_ext;
    logic    dest_rt;

    assign opcode     = opcode_t'(ir[31:26]);
    assign funct      = funct_t'(ir[5:0]);
    assign rs         = ir[25:21];
    assign rt         = ir[20:16];
    assign shamt      = ir[10:6];
    assign jump_index = ir[25:0];

    assign dest    = dest_rt ? ir[20:16] : ir[15:11];
    assign imm_ext = zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

    always_comb begin
        alu_op    = ALU_ADD;
        use_imm   = 1'b0;
        zero_ext  = 1'b0;
        dest_rt   = 1'b1;
        reg_write = 1'b0;
        is_load   = 1'b0;
        is_store  = 1'b0;
        branch    = BR_NONE;
        case (opcode)
            OP_SPECIAL: begin
                dest_rt   = 1'b0;
                reg_write = 1'b1;
                case (funct)
                    F_ADDU: alu_op = ALU_ADD;
                    F_SUBU: alu_op = ALU_SUB;
                    F_AND:  alu_op = ALU_AND;
                    F_OR:   alu_op = ALU_OR;
                    F_XOR:  alu_op = ALU_XOR;
                    F_SLT:  alu_op = ALU_SLT;
                    F_SLTU: alu_op = ALU_SLTU;
                    F_SLL:  alu_op = ALU_SLL;
                    F_SRL:  alu_op = ALU_SRL;
                    F_SRA:  alu_op = ALU_SRA;
                    F_JR: begin
                        reg_write = 1'b0;
                        branch    = BR_JR;
                    end
                    default: reg_write = 1'b0;
                endcase
            end
            OP_J:   branch = BR_J;
            OP_BEQ: branch = BR_BEQ;
            OP_BNE: branch = BR_BNE;
            OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
                use_imm   = 1'b1;
                reg_write = 1'b1;
                case (opcode)
                    OP_SLTI: alu_op = ALU_SLT;
                    OP_ANDI: alu_op = ALU_AND;
                    OP_ORI:  alu_op = ALU_OR;
                    OP_XORI: alu_op = ALU_XOR;
                    OP_LUI:  alu_op = ALU_LUI;
                    default: alu_op = ALU_ADD;
                endcase
                // Logical immediates are zero-extended
                zero_ext = (opcode == OP_ANDI) || (opcode == OP_ORI) || (opcode == OP_XORI);
            end
            OP_LW: begin
                use_imm = 1'b1;
                is_load = 1'b1;
            end
            OP_SW: begin
                use_imm  = 1'b1;
                is_store = 1'b1;
            end
            default: branch = BR_NONE;
        endcase
    end

endmodule

`default_nettype wire

/* source/reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire logic           clk,
    input  wire logic           reset,
    input  mips_pkg::reg_addr_t rs_addr,
    input  mips_pkg::reg_addr_t rt_addr,
    input  wire logic           wr_en,
    input  mips_pkg::reg_addr_t wr_addr,
    input  mips_pkg::word_t     wr_data,
    output mips_pkg::word_t     rs_data,
    output mips_pkg::word_t     rt_data,
    output mips_pkg::word_t     v0
);
    import mips_pkg::*;

    word_t regs [2**REG_ADDR_W];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Register 0 reads as zero regardless of contents
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];
    assign v0      = regs[2];

endmodule

`default_nettype wire

/* source/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b_reg,
    input  mips_pkg::word_t   b_imm,
    input  wire logic         use_imm,
    input  wire logic [4:0]   shamt,
    input  mips_pkg::alu_op_t alu_op,
    output mips_pkg::word_t   result
);
    import mips_pkg::*;

    word_t b;
    logic  lt_signed;
    logic  lt_unsigned;

    assign b           = use_imm ? b_imm : b_reg;
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_AND:  result = a & b;
            ALU_OR:   result = a | b;
            ALU_XOR:  result = a ^ b;
            ALU_SLT:  result = {{(DATA_W-1){1'b0}}, lt_signed};
            ALU_SLTU: result = {{(DATA_W-1){1'b0}}, lt_unsigned};
            // Shifts act on the rt operand
            ALU_SLL:  result = b_reg << shamt;
            ALU_SRL:  result = b_reg >> shamt;
            ALU_SRA:  result = word_t'($signed(b_reg) >>> shamt);
            ALU_LUI:  result = {b_imm[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/cpu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  wire logic          clk,
    input  wire logic          reset,
    input  wire logic          waitrequest,
    input  mips_pkg::word_t    readdata,
    input  mips_pkg::word_t    rs_data,
    input  mips_pkg::word_t    rt_data,
    input  mips_pkg::word_t    alu_result,
    input  mips_pkg::word_t    imm_ext,
    input  wire logic [25:0]   jump_index,
    input  wire logic          reg_write,
    input  wire logic          is_load,
    input  wire logic          is_store,
    input  mips_pkg::branch_t  branch,
    input  mips_pkg::reg_addr_t dest,
    input  mips_pkg::reg_addr_t rt,
    output mips_pkg::word_t    ir,
    output mips_pkg::word_t    address,
    output logic               read,
    output logic               write,
    output mips_pkg::word_t    writedata,
    output mips_pkg::byte_en_t byteenable,
    output logic               active,
    output logic               wr_en,
    output mips_pkg::reg_addr_t wr_addr,
    output mips_pkg::word_t    wr_data
);
    import mips_pkg::*;

    state_t state;
    word_t  pc;
    word_t  pc_plus4;
    word_t  next_pc;
    word_t  target;
    word_t  pend_target;
    logic   pending;
    logic   take;
    logic   advance;

    assign pc_plus4 = pc + 32'd4;

    // Branch decision and target are only used in EXEC
    always_comb begin
        take   = 1'b0;
        target = pc_plus4 + {imm_ext[29:0], 2'b00};
        case (branch)
            BR_BEQ: take = (rs_data == rt_data);
            BR_BNE: take = (rs_data != rt_data);
            BR_J: begin
                take   = 1'b1;
                target = {pc_plus4[31:28], jump_index, 2'b00};
            end
            BR_JR: begin
                take   = 1'b1;
                target = rs_data;
            end
            default: take = 1'b0;
        endcase
        take = take && (state == EXEC);
    end

    // The delay slot instruction leaves before the pending target is used
    assign next_pc = pending ? pend_target : pc_plus4;
    assign advance = ((state == EXEC) && !is_load && !is_store)
                  || ((state == MEM) && !waitrequest);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH;
            pc      <= RESET_VECTOR;
            pending <= 1'b0;
        end else begin
            case (state)
                FETCH: if (!waitrequest) state <= EXEC;
                EXEC: if (is_load || is_store) state <= MEM;
                default: state <= state;
            endcase
            if (advance) begin
                pc      <= next_pc;
                pending <= take;
                state   <= (next_pc == HALT_ADDR) ? HALTED : FETCH;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            ir <= readdata;
        end
        if (take) begin
            pend_target <= target;
        end
    end

    // Bus outputs stay steady while waitrequest holds the state
    always_comb begin
        read    = 1'b0;
        write   = 1'b0;
        address = pc;
        case (state)
            FETCH: read = 1'b1;
            MEM: begin
                read    = is_load;
                write   = is_store;
                address = alu_result;
            end
            default: read = 1'b0;
        endcase
    end

    assign writedata  = rt_data;
    assign byteenable = '1;
    assign active     = (state != HALTED);

    // Write back from the ALU in EXEC, from the bus when a load completes
    assign wr_en   = ((state == EXEC) && reg_write)
                  || ((state == MEM) && is_load && !waitrequest);
    assign wr_addr = (state == MEM) ? rt : dest;
    assign wr_data = (state == MEM) ? readdata : alu_result;

    bus_excl: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else $error("read and write asserted together");

    no_branch_in_slot: assert property (@(posedge clk) disable iff (reset)
        (state == EXEC && pending) |-> (branch == BR_NONE))
        else $error("branch in delay slot at pc %h", pc);

    data_aligned: assert property (@(posedge clk) disable iff (reset)
        (state == MEM) |-> (address[1:0] == 2'b00))
        else $error("unaligned data access at %h", address);

endmodule

`default_nettype wire

/* source/mips_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_bus (
    input  wire logic               clk,
    input  wire logic               reset,
    output logic                    active,
    output mips_pkg::word_t         register_v0,
    output mips_pkg::word_t         address,
    output logic                    read,
    output logic                    write,
    input  wire logic               waitrequest,
    output mips_pkg::word_t         writedata,
    output mips_pkg::byte_en_t      byteenable,
    input  mips_pkg::word_t         readdata
);
    import mips_pkg::*;

    word_t     ir;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t dest;
    logic [4:0] shamt;
    alu_op_t   alu_op;
    logic      use_imm;
    word_t     imm_ext;
    logic      reg_write;
    logic      is_load;
    logic      is_store;
    branch_t   branch;
    logic [25:0] jump_index;

    word_t     rs_data;
    word_t     rt_data;
    word_t     alu_result;

    logic      wr_en;
    reg_addr_t wr_addr;
    word_t     wr_data;

    cpu_control cpu_control_inst (
        .clk(clk), .reset(reset), .waitrequest(waitrequest), .readdata(readdata),
        .rs_data(rs_data), .rt_data(rt_data), .alu_result(alu_result), .imm_ext(imm_ext),
        .jump_index(jump_index), .reg_write(reg_write), .is_load(is_load),
        .is_store(is_store), .branch(branch), .dest(dest), .rt(rt),
        .ir(ir), .address(address), .read(read), .write(write), .writedata(writedata),
        .byteenable(byteenable), .active(active),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    instr_decode instr_decode_inst (
        .ir(ir), .rs(rs), .rt(rt), .dest(dest), .shamt(shamt), .alu_op(alu_op),
        .use_imm(use_imm), .imm_ext(imm_ext), .reg_write(reg_write), .is_load(is_load),
        .is_store(is_store), .branch(branch), .jump_index(jump_index)
    );

    reg_file reg_file_inst (
        .clk(clk), .reset(reset), .rs_addr(rs), .rt_addr(rt),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rs_data(rs_data), .rt_data(rt_data), .v0(register_v0)
    );

    alu alu_inst (
        .a(rs_data), .b_reg(rt_data), .b_imm(imm_ext), .use_imm(use_imm),
        .shamt(shamt), .alu_op(alu_op), .result(alu_result)
    );

endmodule

`default_nettype wire

/* tests/mips_bus_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_bus_memory (
    input  wire logic          clk,
    input  wire logic          reset,
    input  mips_pkg::word_t    address,
    input  wire logic          read,
    input  wire logic          write,
    input  mips_pkg::word_t    writedata,
    input  mips_pkg::byte_en_t byteenable,
    output logic               waitrequest,
    output mips_pkg::word_t    readdata
);
    import mips_pkg::*;

    word_t       mem [word_t];
    word_t       wr_addr_q [$];
    word_t       wr_data_q [$];
    logic [31:0] lfsr_state = 32'h6cbe0bf2;

    // Galois LFSR stepped once per bit drawn
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    // Unwritten locations return a pattern tied to the full address
    function automatic word_t read_word(word_t addr);
        return mem.exists(addr) ? mem[addr] : ~addr;
    endfunction

    // Only the enabled byte lanes of a store reach memory
    function automatic word_t merge_lanes(word_t old, word_t data, byte_en_t be);
        word_t res;
        res = old;
        for (int i = 0; i < DATA_W/8; i++) begin
            if (be[i]) begin
                res[8*i +: 8] = data[8*i +: 8];
            end
        end
        return res;
    endfunction

    task automatic clear();
        mem.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
    endtask

    task automatic load_word(word_t addr, word_t data);
        mem[addr] = data;
    endtask

    initial begin
        waitrequest = 1'b0;
    end

    // About one cycle in four is stalled
    always @(posedge clk) begin
        #1 waitrequest = lfsr_bit() & lfsr_bit();
    end

    always @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            mem[address] = merge_lanes(read_word(address), writedata, byteenable);
            wr_addr_q.push_back(address);
            wr_data_q.push_back(mem[address]);
        end
    end

    assign readdata = read ? read_word(address) : '0;

endmodule

`default_nettype wire

/* tests/tb_mips_cpu_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam int RESET_CYCLES = 8;
    localparam int HALT_WAIT    = 10;
    localparam int NUM_TESTS    = 3;
    localparam int STEP_BUDGET  = 120;
    localparam int WATCHDOG_CYCLES =
        NUM_TESTS * (RESET_CYCLES + HALT_WAIT + 4) + NUM_TESTS * STEP_BUDGET * 20;

    localparam logic [5:0] OPC_J = 6'h02, OPC_BEQ = 6'h04, OPC_BNE = 6'h05;
    localparam logic [5:0] OPC_ADDIU = 6'h09, OPC_SLTI = 6'h0A, OPC_ANDI = 6'h0C;
    localparam logic [5:0] OPC_ORI = 6'h0D, OPC_XORI = 6'h0E, OPC_LUI = 6'h0F;
    localparam logic [5:0] OPC_LW = 6'h23, OPC_SW = 6'h2B;
    localparam logic [5:0] FN_SLL = 6'h00, FN_SRL = 6'h02, FN_SRA = 6'h03, FN_JR = 6'h08;
    localparam logic [5:0] FN_ADDU = 6'h21, FN_SUBU = 6'h23, FN_AND = 6'h24, FN_OR = 6'h25;
    localparam logic [5:0] FN_XOR = 6'h26, FN_SLT = 6'h2A, FN_SLTU = 6'h2B;

    logic     clk = 1'b0;
    logic     reset = 1'b1;
    logic     active, read, write, waitrequest;
    word_t    register_v0, address, writedata, readdata;
    byte_en_t byteenable;

    word_t prog [$];
    word_t ref_mem [word_t];
    word_t exp_addr_q [$];
    word_t exp_data_q [$];
    string test_name = "reset";
    int    errors = 0;
    int    checks = 0;

    mips_cpu_bus mips_cpu_bus_inst (
        .clk(clk), .reset(reset), .active(active), .register_v0(register_v0),
        .address(address), .read(read), .write(write), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    mips_bus_memory mem_inst (
        .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
        .writedata(writedata), .byteenable(byteenable), .waitrequest(waitrequest),
        .readdata(readdata)
    );

    always #5 clk = ~clk;

    task automatic check_word(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_bit(string name, logic expected, logic actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR: %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_byte_en(string name, byte_en_t expected, byte_en_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("ERROR: %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_store(string name, word_t exp_a, word_t exp_d, word_t act_a,
                               word_t act_d);
        checks++;
        if (exp_a !== act_a || exp_d !== act_d) begin
            errors++;
            $display("ERROR: %s expected %h <= %h actual %h <= %h",
                     name, exp_a, exp_d, act_a, act_d);
        end
    endtask

    function automatic word_t enc_r(logic [5:0] fn, reg_addr_t rd, reg_addr_t rs,
                                    reg_addr_t rt, logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(logic [5:0] op, reg_addr_t rt, reg_addr_t rs,
                                    logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t ref_read(word_t addr);
        return ref_mem.exists(addr) ? ref_mem[addr] : ~addr;
    endfunction

    // Instruction-level model with one delay slot per branch or jump
    function automatic word_t reference_run();
        word_t regs [32];
        word_t pc, npc, ins, a, b, simm, zimm, tgt;
        logic [5:0] op, fn;
        reg_addr_t rs, rt, rd;
        logic [4:0] sa;
        logic taken;
        int steps;
        foreach (regs[i]) regs[i] = '0;
        pc = RESET_VECTOR;
        npc = pc + 4;
        steps = 0;
        while (pc != HALT_ADDR && steps < STEP_BUDGET) begin
            ins = ref_read(pc);
            op = ins[31:26];
            fn = ins[5:0];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            sa = ins[10:6];
            a = regs[rs];
            b = regs[rt];
            simm = {{16{ins[15]}}, ins[15:0]};
            zimm = {16'h0000, ins[15:0]};
            taken = 1'b0;
            tgt = pc + 4 + (simm << 2);
            case (op)
                6'h00: case (fn)
                    FN_ADDU: regs[rd] = a + b;
                    FN_SUBU: regs[rd] = a - b;
                    FN_AND:  regs[rd] = a & b;
                    FN_OR:   regs[rd] = a | b;
                    FN_XOR:  regs[rd] = a ^ b;
                    FN_SLT:  regs[rd] = ($signed(a) < $signed(b)) ? 1 : 0;
                    FN_SLTU: regs[rd] = (a < b) ? 1 : 0;
                    FN_SLL:  regs[rd] = b << sa;
                    FN_SRL:  regs[rd] = b >> sa;
                    FN_SRA:  regs[rd] = $signed(b) >>> sa;
                    FN_JR: begin
                        taken = 1'b1;
                        tgt = a;
                    end
                    default: ;
                endcase
                OPC_ADDIU: regs[rt] = a + simm;
                OPC_SLTI:  regs[rt] = ($signed(a) < $signed(simm)) ? 1 : 0;
                OPC_ANDI:  regs[rt] = a & zimm;
                OPC_ORI:   regs[rt] = a | zimm;
                OPC_XORI:  regs[rt] = a ^ zimm;
                OPC_LUI:   regs[rt] = {ins[15:0], 16'h0000};
                OPC_LW:    regs[rt] = ref_read(a + simm);
                OPC_SW: begin
                    ref_mem[a + simm] = b;
                    exp_addr_q.push_back(a + simm);
                    exp_data_q.push_back(b);
                end
                OPC_BEQ: taken = (a == b);
                OPC_BNE: taken = (a != b);
                OPC_J: begin
                    taken = 1'b1;
                    tgt = {npc[31:28], ins[25:0], 2'b00};
                end
                default: ;
            endcase
            regs[0] = '0;
            pc = npc;
            npc = taken ? tgt : npc + 4;
            steps++;
        end
        return regs[2];
    endfunction

    task automatic build_alu_prog();
        prog = '{enc_i(OPC_LUI, 1, 0, 16'h1234), enc_i(OPC_ORI, 1, 1, 16'h8765),
                 enc_i(OPC_ADDIU, 3, 0, 16'hFFFB), enc_i(OPC_ADDIU, 5, 0, 16'h0F00),
                 enc_r(FN_ADDU, 2, 1, 3, 0), enc_r(FN_SUBU, 2, 2, 3, 0),
                 enc_r(FN_XOR, 2, 2, 3, 0), enc_r(FN_OR, 2, 2, 5, 0),
                 enc_r(FN_AND, 2, 2, 3, 0), enc_r(FN_SLT, 4, 3, 1, 0),
                 enc_r(FN_ADDU, 2, 2, 4, 0), enc_r(FN_SLTU, 4, 3, 1, 0),
                 enc_r(FN_ADDU, 2, 2, 4, 0), enc_r(FN_SLL, 4, 0, 1, 4),
                 enc_r(FN_XOR, 2, 2, 4, 0), enc_r(FN_SRL, 4, 0, 3, 3),
                 enc_r(FN_ADDU, 2, 2, 4, 0), enc_r(FN_SRA, 4, 0, 3, 2),
                 enc_r(FN_XOR, 2, 2, 4, 0), enc_i(OPC_ANDI, 4, 3, 16'hF0F0),
                 enc_r(FN_XOR, 2, 2, 4, 0), enc_i(OPC_XORI, 2, 2, 16'hA5A5),
                 enc_i(OPC_SLTI, 4, 3, 16'h0001), enc_r(FN_ADDU, 2, 2, 4, 0),
                 enc_r(FN_JR, 0, 0, 0, 0), 32'h0};
    endtask

    task automatic build_mem_prog();
        prog = '{enc_i(OPC_ADDIU, 5, 0, 16'h1000), enc_i(OPC_ADDIU, 1, 0, 16'h1234),
                 enc_i(OPC_SW, 1, 5, 16'h0000), enc_i(OPC_LUI, 6, 0, 16'hDEAD),
                 enc_i(OPC_ORI, 6, 6, 16'hBEEF), enc_i(OPC_SW, 6, 5, 16'h0004),
                 enc_i(OPC_LW, 2, 5, 16'h0000), enc_r(FN_ADDU, 2, 2, 6, 0),
                 enc_i(OPC_SW, 2, 5, 16'h0008), enc_i(OPC_LW, 2, 5, 16'h0004),
                 enc_r(FN_JR, 0, 0, 0, 0), 32'h0};
    endtask

    // Untaken and taken branches, J, JR and a backward loop
    task automatic build_branch_prog();
        prog = '{enc_i(OPC_ADDIU, 1, 0, 16'd1), enc_i(OPC_ADDIU, 2, 0, 16'd0),
                 enc_i(OPC_BEQ, 0, 1, 16'd2), enc_i(OPC_ADDIU, 2, 2, 16'd1),
                 enc_i(OPC_BNE, 0, 1, 16'd2), enc_i(OPC_ADDIU, 2, 2, 16'd2),
                 enc_i(OPC_ADDIU, 2, 2, 16'd100), enc_i(OPC_BEQ, 0, 0, 16'd2),
                 enc_i(OPC_ADDIU, 2, 2, 16'd4), enc_i(OPC_ADDIU, 2, 2, 16'd200),
                 {OPC_J, 26'h3F0_000D}, enc_i(OPC_ADDIU, 2, 2, 16'd8),
                 enc_i(OPC_ADDIU, 2, 2, 16'd300), enc_i(OPC_LUI, 7, 0, 16'hBFC0),
                 enc_i(OPC_ORI, 7, 7, 16'h0050), enc_r(FN_JR, 0, 7, 0, 0),
                 enc_i(OPC_ADDIU, 2, 2, 16'd16), enc_i(OPC_ADDIU, 2, 2, 16'd400),
                 enc_i(OPC_ADDIU, 2, 2, 16'd400), enc_i(OPC_ADDIU, 2, 2, 16'd400),
                 enc_i(OPC_ADDIU, 8, 8, 16'd1), enc_i(OPC_SLTI, 9, 8, 16'd3),
                 enc_i(OPC_BNE, 0, 9, 16'hFFFD), enc_i(OPC_ADDIU, 2, 2, 16'd32),
                 enc_r(FN_JR, 0, 0, 0, 0), 32'h0};
    endtask

    task automatic run_test(string name);
        word_t exp_v0;
        word_t v0_at_halt;
        int n;
        test_name = name;
        mem_inst.clear();
        ref_mem.delete();
        exp_addr_q.delete();
        exp_data_q.delete();
        foreach (prog[i]) begin
            mem_inst.load_word(RESET_VECTOR + 4 * i, prog[i]);
            ref_mem[RESET_VECTOR + 4 * i] = prog[i];
        end
        exp_v0 = reference_run();
        @(posedge clk);
        #1 reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_bit({name, " write in reset"}, 1'b0, write);
        end
        @(posedge clk);
        #1 reset = 1'b0;
        @(negedge clk);
        check_bit({name, " active after reset"}, 1'b1, active);
        check_bit({name, " first read"}, 1'b1, read);
        check_bit({name, " write after reset"}, 1'b0, write);
        check_word({name, " first address"}, RESET_VECTOR, address);
        check_byte_en({name, " byteenable"}, 4'hF, byteenable);
        while (active) @(negedge clk);
        v0_at_halt = register_v0;
        repeat (HALT_WAIT) begin
            @(negedge clk);
            check_bit({name, " read after halt"}, 1'b0, read);
            check_bit({name, " write after halt"}, 1'b0, write);
            check_word({name, " v0 after halt"}, v0_at_halt, register_v0);
        end
        check_word({name, " register_v0"}, exp_v0, register_v0);
        n = mem_inst.wr_addr_q.size();
        if (n != exp_addr_q.size()) begin
            errors++;
            $display("ERROR: %s made %0d stores but the reference made %0d",
                     name, n, exp_addr_q.size());
        end
        for (int i = 0; i < n && i < exp_addr_q.size(); i++) begin
            check_store($sformatf("%s store %0d", name, i), exp_addr_q[i], exp_data_q[i],
                        mem_inst.wr_addr_q[i], mem_inst.wr_data_q[i]);
        end
    endtask

    // Bus signals must hold while a transfer is stalled
    logic  prev_hold = 1'b0;
    logic  prev_read, prev_write;
    word_t prev_addr, prev_wdata;

    always @(negedge clk) begin
        if (!reset && prev_hold) begin
            check_word({test_name, " stall address"}, prev_addr, address);
            check_bit({test_name, " stall read"}, prev_read, read);
            check_bit({test_name, " stall write"}, prev_write, write);
            if (write) begin
                check_word({test_name, " stall writedata"}, prev_wdata, writedata);
            end
        end
        prev_hold  = !reset && (read || write) && waitrequest;
        prev_read  = read;
        prev_write = write;
        prev_addr  = address;
        prev_wdata = writedata;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: watchdog expired, the CPU never halted in test %s", test_name);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        build_alu_prog();
        run_test("alu");
        build_mem_prog();
        run_test("load_store");
        build_branch_prog();
        run_test("branch_jump");
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
source/mips_pkg.sv
source/instr_decode.sv
source/reg_file.sv
source/alu.sv
source/cpu_control.sv
source/mips_cpu_bus.sv
tests/mips_bus_memory.sv
tests/tb_mips_cpu_bus.sv

/* Bender.yml */
package:
  name: mips_cpu_bus

sources:
  - source/mips_pkg.sv
  - source/instr_decode.sv
  - source/reg_file.sv
  - source/alu.sv
  - source/cpu_control.sv
  - source/mips_cpu_bus.sv
  - target: test
    files:
      - tests/mips_bus_memory.sv
      - tests/tb_mips_cpu_bus.sv
